//--- design/fpuOpsPkg.sv
//**************************************************************************
// Operation set of the RV32F unit and the instruction field values that the
// decoder matches against
//**************************************************************************
`default_nettype none

package fpuOpsPkg;

// Kept operations, OP_NONE covers everything else
typedef enum logic [3:0] {
        OP_NONE,
        OP_FSGNJ,
        OP_FSGNJN,
        OP_FSGNJX,
        OP_FMIN,
        OP_FMAX,
        OP_FEQ,
        OP_FLT,
        OP_FLE,
        OP_FCLASS,
        OP_FMVXW,
        OP_FMVWX,
        OP_FCVTSW,
        OP_FCVTSWU
} fpuOp_e;

localparam logic [6:0] OPCODE_OP_FP = 7'b1010011;
localparam logic [1:0] FMT_S        = 2'b00;

localparam logic [4:0] FUNCT5_SGNJ       = 5'b00100;
localparam logic [4:0] FUNCT5_MINMAX     = 5'b00101;
localparam logic [4:0] FUNCT5_CMP        = 5'b10100;
localparam logic [4:0] FUNCT5_CVTSW      = 5'b11010;
localparam logic [4:0] FUNCT5_MVXW_CLASS = 5'b11100;
localparam logic [4:0] FUNCT5_MVWX       = 5'b11110;

localparam logic [2:0] FUNCT3_SGNJ  = 3'b000;
localparam logic [2:0] FUNCT3_SGNJN = 3'b001;
localparam logic [2:0] FUNCT3_SGNJX = 3'b010;
localparam logic [2:0] FUNCT3_MIN   = 3'b000;
localparam logic [2:0] FUNCT3_MAX   = 3'b001;
localparam logic [2:0] FUNCT3_FLE   = 3'b000;
localparam logic [2:0] FUNCT3_FLT   = 3'b001;
localparam logic [2:0] FUNCT3_FEQ   = 3'b010;
localparam logic [2:0] FUNCT3_MV    = 3'b000;
localparam logic [2:0] FUNCT3_CLASS = 3'b001;

// rs2 field selects signed or unsigned source on conversions
localparam logic [4:0] RS2_W  = 5'd0;
localparam logic [4:0] RS2_WU = 5'd1;

endpackage

`default_nettype wire

//--- design/fpuDataPkg.sv
//**************************************************************************
// Single-precision number format, FCLASS encodings and the unpacked operand
// record shared by the classifier, comparator and result unit
//**************************************************************************
`default_nettype none

package fpuDataPkg;

localparam int EXP_W    = 8;
localparam int SIG_W    = 23;
localparam int EXP_BIAS = 127;

localparam logic [31:0] CANON_NAN = 32'h7FC00000;

// FCLASS mask, bit 0 is negative infinity
typedef logic [9:0] fclass_t;

localparam fclass_t CLASS_NEG_INF  = 10'b00_0000_0001;
localparam fclass_t CLASS_NEG_NORM = 10'b00_0000_0010;
localparam fclass_t CLASS_NEG_SUB  = 10'b00_0000_0100;
localparam fclass_t CLASS_NEG_ZERO = 10'b00_0000_1000;
localparam fclass_t CLASS_POS_ZERO = 10'b00_0001_0000;
localparam fclass_t CLASS_POS_SUB  = 10'b00_0010_0000;
localparam fclass_t CLASS_POS_NORM = 10'b00_0100_0000;
localparam fclass_t CLASS_POS_INF  = 10'b00_1000_0000;
localparam fclass_t CLASS_SNAN     = 10'b01_0000_0000;
localparam fclass_t CLASS_QNAN     = 10'b10_0000_0000;

localparam fclass_t CLASS_NAN_MASK  = CLASS_SNAN | CLASS_QNAN;
localparam fclass_t CLASS_ZERO_MASK = CLASS_NEG_ZERO | CLASS_POS_ZERO;

typedef struct packed {
        logic [31:0]      raw;
        logic             sign;
        logic [EXP_W-1:0] exp;
        logic [SIG_W:0]   sig;   // hidden bit on top
        fclass_t          cls;
} fOperand_t;

endpackage

`default_nettype wire

//--- design/FDecode.sv
//**************************************************************************
// RV32F instruction decoder, maps an instruction word onto one operation
//**************************************************************************
`default_nettype none

module FDecode (
        input  logic [31:0]       instr_i,
        output fpuOpsPkg::fpuOp_e op_o
);

import fpuOpsPkg::*;

logic [4:0] funct5;
logic [2:0] funct3;
logic [4:0] rs2Field;
logic       isOpFp;
logic [OP_FCVTSWU:OP_FSGNJ] hit;

assign funct5   = instr_i[31:27];
assign funct3   = instr_i[14:12];
assign rs2Field = instr_i[24:20];

// FMA group has its own opcodes and never gets past this
assign isOpFp = (instr_i[6:0] == OPCODE_OP_FP) && (instr_i[26:25] == FMT_S);

assign hit[OP_FSGNJ]   = isOpFp && (funct5 == FUNCT5_SGNJ) && (funct3 == FUNCT3_SGNJ);
assign hit[OP_FSGNJN]  = isOpFp && (funct5 == FUNCT5_SGNJ) && (funct3 == FUNCT3_SGNJN);
assign hit[OP_FSGNJX]  = isOpFp && (funct5 == FUNCT5_SGNJ) && (funct3 == FUNCT3_SGNJX);
assign hit[OP_FMIN]    = isOpFp && (funct5 == FUNCT5_MINMAX) && (funct3 == FUNCT3_MIN);
assign hit[OP_FMAX]    = isOpFp && (funct5 == FUNCT5_MINMAX) && (funct3 == FUNCT3_MAX);
assign hit[OP_FEQ]     = isOpFp && (funct5 == FUNCT5_CMP) && (funct3 == FUNCT3_FEQ);
assign hit[OP_FLT]     = isOpFp && (funct5 == FUNCT5_CMP) && (funct3 == FUNCT3_FLT);
assign hit[OP_FLE]     = isOpFp && (funct5 == FUNCT5_CMP) && (funct3 == FUNCT3_FLE);
assign hit[OP_FCLASS]  = isOpFp && (funct5 == FUNCT5_MVXW_CLASS) &&
                         (funct3 == FUNCT3_CLASS) && (rs2Field == RS2_W);
assign hit[OP_FMVXW]   = isOpFp && (funct5 == FUNCT5_MVXW_CLASS) &&
                         (funct3 == FUNCT3_MV) && (rs2Field == RS2_W);
assign hit[OP_FMVWX]   = isOpFp && (funct5 == FUNCT5_MVWX) &&
                         (funct3 == FUNCT3_MV) && (rs2Field == RS2_W);

// funct3 is the rounding mode here and is ignored
assign hit[OP_FCVTSW]  = isOpFp && (funct5 == FUNCT5_CVTSW) && (rs2Field == RS2_W);
assign hit[OP_FCVTSWU] = isOpFp && (funct5 == FUNCT5_CVTSW) && (rs2Field == RS2_WU);

always_comb begin
        op_o = OP_NONE;
        for (int i = OP_FSGNJ; i <= OP_FCVTSWU; i++) begin
                if (hit[i]) begin
                        op_o = fpuOp_e'(i);
                end
        end
end

// Match terms must exclude each other or the loop above picks silently
always_comb begin
        assert ($onehot0(hit))
                else $error("FDecode: overlapping match terms %b", hit);
end

endmodule

`default_nettype wire

//--- design/FClass.sv
//**************************************************************************
// Operand classifier, unpacks a register value into its fields and its
// one-hot FCLASS bit for the comparator and result unit
//**************************************************************************
`default_nettype none

module FClass (
        input  logic [31:0]           reg_i,
        output fpuDataPkg::fOperand_t operand_o
);

import fpuDataPkg::*;

logic             sign;
logic [EXP_W-1:0] expField;
logic [SIG_W-1:0] fracField;
logic             expZero;
logic             expOnes;
logic             fracZero;
fclass_t          cls;

assign sign      = reg_i[31];
assign expField  = reg_i[30:SIG_W];
assign fracField = reg_i[SIG_W-1:0];

assign expZero  = (expField == '0);
assign expOnes  = (expField == '1);
assign fracZero = (fracField == '0);

always_comb begin
        if (expOnes) begin
                if (fracZero) begin
                        cls = sign ? CLASS_NEG_INF : CLASS_POS_INF;
                end else begin
                        // Top fraction bit set means quiet
                        cls = fracField[SIG_W-1] ? CLASS_QNAN : CLASS_SNAN;
                end
        end else if (expZero) begin
                if (fracZero) begin
                        cls = sign ? CLASS_NEG_ZERO : CLASS_POS_ZERO;
                end else begin
                        cls = sign ? CLASS_NEG_SUB : CLASS_POS_SUB;
                end
        end else begin
                cls = sign ? CLASS_NEG_NORM : CLASS_POS_NORM;
        end
end

assign operand_o = '{
        raw:  reg_i,
        sign: sign,
        exp:  expField,
        sig:  {~expZero, fracField},
        cls:  cls
};

endmodule

`default_nettype wire

//--- design/FCMP.sv
//**************************************************************************
// IEEE comparator for two classified operands, output is {lt, le, eq}
//**************************************************************************
`default_nettype none

module FCMP (
        input  fpuDataPkg::fOperand_t rs1_i,
        input  fpuDataPkg::fOperand_t rs2_i,
        output logic [2:0]            cmp_o
);

import fpuDataPkg::*;

logic anyNan;
logic bothZero;
logic magLt;
logic magEq;
logic lt;
logic eq;

assign anyNan   = |((rs1_i.cls | rs2_i.cls) & CLASS_NAN_MASK);
assign bothZero = |(rs1_i.cls & CLASS_ZERO_MASK) && |(rs2_i.cls & CLASS_ZERO_MASK);

// Hidden bit follows the exponent, so this orders magnitudes
assign magLt = {rs1_i.exp, rs1_i.sig} < {rs2_i.exp, rs2_i.sig};
assign magEq = {rs1_i.exp, rs1_i.sig} == {rs2_i.exp, rs2_i.sig};

assign eq = bothZero || ((rs1_i.sign == rs2_i.sign) && magEq);

always_comb begin
        if (bothZero) begin
                lt = 1'b0;
        end else if (rs1_i.sign != rs2_i.sign) begin
                lt = rs1_i.sign;
        end else if (rs1_i.sign) begin
                // Both negative, larger magnitude is smaller
                lt = !magLt && !magEq;
        end else begin
                lt = magLt;
        end
end

assign cmp_o = anyNan ? 3'b000 : {lt, lt | eq, eq};

endmodule

`default_nettype wire

//--- design/FCVT.sv
//**************************************************************************
// Sequential integer to float converter, one bit of normalization per cycle
// then round to nearest even, busy_o stays high until the result is packed
//**************************************************************************
`default_nettype none

module FCVT (
        input  logic              clk_i,
        input  logic              reset_i,
        input  logic              enable_i,
        input  fpuOpsPkg::fpuOp_e op_i,
        input  logic [31:0]       int_i,
        output logic              busy_o,
        output logic [31:0]       result_o
);

import fpuOpsPkg::*;
import fpuDataPkg::*;

typedef enum logic [2:0] {
        IDLE,
        ABS,
        NORM,
        ROUND,
        DONE
} cvtState_e;

cvtState_e        state;
fpuOp_e           opReg;
logic             isCvt;
logic             negIn;
logic [31:0]      absVal;
logic             signReg;
logic [31:0]      mag;
logic [EXP_W-1:0] expReg;
logic             roundUp;
logic [SIG_W+1:0] rounded;

assign isCvt  = (op_i == OP_FCVTSW) || (op_i == OP_FCVTSWU);
assign busy_o = (state == IDLE) ? (enable_i && isCvt) : (state != DONE);

assign negIn  = (opReg == OP_FCVTSW) && mag[31];
assign absVal = negIn ? -mag : mag;

// Guard is mag[7], sticky the bits below, lsb mag[8]
assign roundUp = mag[7] && ((|mag[6:0]) || mag[8]);
assign rounded = {1'b0, mag[31:8]} + {{(SIG_W+1){1'b0}}, roundUp};

always_ff @(posedge clk_i) begin
        if (reset_i) begin
                state <= IDLE;
                opReg <= OP_NONE;
        end else begin
                case (state)
                        IDLE: if (enable_i && isCvt) begin
                                opReg <= op_i;
                                state <= (int_i == 32'b0) ? DONE : ABS;
                        end
                        ABS:   state <= absVal[31] ? ROUND : NORM;
                        NORM:  state <= mag[30] ? ROUND : NORM;
                        ROUND: state <= DONE;
                        // Hold the result until the core moves on
                        DONE: if (!enable_i || (op_i != opReg)) begin
                                state <= IDLE;
                        end
                        default: state <= IDLE;
                endcase
        end
end

always_ff @(posedge clk_i) begin
        case (state)
                IDLE: begin
                        mag      <= int_i;
                        result_o <= 32'b0;
                end
                ABS: begin
                        signReg <= negIn;
                        mag     <= absVal;
                        expReg  <= EXP_W'(EXP_BIAS + 31);
                end
                NORM: begin
                        mag    <= mag << 1;
                        expReg <= expReg - 1'b1;
                end
                // A carry out leaves the fraction zero and bumps the exponent
                ROUND: result_o <= {signReg, expReg + rounded[SIG_W+1], rounded[SIG_W-1:0]};
                default: ;
        endcase
end

busyOnlyOnConvert: assert property (@(posedge clk_i) disable iff (reset_i)
        busy_o |-> (isCvt && enable_i))
        else $error("FCVT: busy_o high without a convert op");

endmodule

`default_nettype wire

//--- design/FResult.sv
//**************************************************************************
// Result unit, forms sign injection, min/max, compare, class, move and
// conversion results and selects one by the decoded operation
//**************************************************************************
`default_nettype none

module FResult (
        input  fpuOpsPkg::fpuOp_e     op_i,
        input  fpuDataPkg::fOperand_t opA_i,
        input  fpuDataPkg::fOperand_t opB_i,
        input  logic [2:0]            cmp_i,
        input  logic [31:0]           cvt_i,
        output logic [31:0]           result_o
);

import fpuOpsPkg::*;
import fpuDataPkg::*;

logic        aNan;
logic        bNan;
logic        aLess;
logic [31:0] minMax;

assign aNan = |(opA_i.cls & CLASS_NAN_MASK);
assign bNan = |(opB_i.cls & CLASS_NAN_MASK);

// -0 orders below +0 for min and max
assign aLess = cmp_i[2] || (cmp_i[0] && opA_i.sign && !opB_i.sign);

always_comb begin
        if (aNan && bNan) begin
                minMax = CANON_NAN;
        end else if (aNan) begin
                minMax = opB_i.raw;
        end else if (bNan) begin
                minMax = opA_i.raw;
        end else if (aLess ^ (op_i == OP_FMAX)) begin
                minMax = opA_i.raw;
        end else begin
                minMax = opB_i.raw;
        end
end

always_comb begin
        case (op_i)
                OP_FSGNJ:              result_o = {opB_i.sign, opA_i.raw[30:0]};
                OP_FSGNJN:             result_o = {~opB_i.sign, opA_i.raw[30:0]};
                OP_FSGNJX:             result_o = {opA_i.sign ^ opB_i.sign, opA_i.raw[30:0]};
                OP_FMIN, OP_FMAX:      result_o = minMax;
                OP_FEQ:                result_o = {31'b0, cmp_i[0]};
                OP_FLE:                result_o = {31'b0, cmp_i[1]};
                OP_FLT:                result_o = {31'b0, cmp_i[2]};
                OP_FCLASS:             result_o = {22'b0, opA_i.cls};
                OP_FMVXW, OP_FMVWX:    result_o = opA_i.raw;
                OP_FCVTSW, OP_FCVTSWU: result_o = cvt_i;
                default:               result_o = 32'b0;
        endcase
end

endmodule

`default_nettype wire

//--- design/FPU.sv
//**************************************************************************
// Single-precision FPU top for an RV32F core, combinational except for
// integer conversion which raises busy_o while it runs
//**************************************************************************
`default_nettype none

module FPU (
        input  logic        clk_i,
        input  logic        reset_i,

        input  logic        fpuEnable_i,
        input  logic [31:0] instr_i,
        input  logic [31:0] rs1_i,
        input  logic [31:0] rs2_i,

        output logic        busy_o,
        output logic [31:0] fpuOut_o
);

import fpuOpsPkg::*;
import fpuDataPkg::*;

fpuOp_e      op;
fOperand_t   opA;
fOperand_t   opB;
logic [2:0]  cmp;   // {lt, le, eq}
logic [31:0] cvtResult;
logic        cvtBusy;

FDecode decode (.instr_i(instr_i), .op_o(op));

// Operand unpacking
FClass class1 (.reg_i(rs1_i), .operand_o(opA));
FClass class2 (.reg_i(rs2_i), .operand_o(opB));

FCMP fcmp (.rs1_i(opA), .rs2_i(opB), .cmp_o(cmp));

FCVT fcvt (
        .clk_i(clk_i),
        .reset_i(reset_i),
        .enable_i(fpuEnable_i),
        .op_i(op),
        .int_i(rs1_i),
        .busy_o(cvtBusy),
        .result_o(cvtResult)
);

FResult result (
        .op_i(op),
        .opA_i(opA),
        .opB_i(opB),
        .cmp_i(cmp),
        .cvt_i(cvtResult),
        .result_o(fpuOut_o)
);

assign busy_o = cvtBusy;

endmodule

`default_nettype wire

//--- include/fpuModel.svh
//**************************************************************************
// Reference model and random source for the FPU testbench, included inside
// the testbench module
//**************************************************************************
`ifndef FPU_MODEL_SVH
`define FPU_MODEL_SVH

localparam logic [31:0] LCG_SEED = 32'hbe3d;

function automatic logic [31:0] lcg(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
endfunction

// OP-FP instruction word with rs1 = x1, rd = x2
function automatic logic [31:0] fpInstr(input logic [4:0] funct5, input logic [4:0] rs2,
                                        input logic [2:0] funct3);
        return {funct5, 2'b00, rs2, 5'd1, funct3, 5'd2, 7'b1010011};
endfunction

function automatic logic modelIsNan(input logic [31:0] x);
        return (x[30:23] == 8'hff) && (x[22:0] != 23'b0);
endfunction

function automatic logic modelIsZero(input logic [31:0] x);
        return x[30:0] == 31'b0;
endfunction

function automatic logic [31:0] modelSgnj(input logic [31:0] a, input logic [31:0] b,
                                          input logic [1:0] kind);
        case (kind)
                2'd0:    return {b[31], a[30:0]};
                2'd1:    return {~b[31], a[30:0]};
                default: return {a[31] ^ b[31], a[30:0]};
        endcase
endfunction

function automatic logic [9:0] modelClass(input logic [31:0] x);
        int idx;
        if (x[30:23] == 8'hff) begin
                idx = (x[22:0] == 0) ? (x[31] ? 0 : 7) : (x[22] ? 9 : 8);
        end else if (x[30:23] == 8'h00) begin
                idx = (x[22:0] == 0) ? (x[31] ? 3 : 4) : (x[31] ? 2 : 5);
        end else begin
                idx = x[31] ? 1 : 6;
        end
        return 10'b1 << idx;
endfunction

// Result is {lt, le, eq}
function automatic logic [2:0] modelCmp(input logic [31:0] a, input logic [31:0] b);
        logic [31:0] keyA;
        logic [31:0] keyB;
        logic        lt;
        logic        eq;
        if (modelIsNan(a) || modelIsNan(b)) begin
                return 3'b000;
        end
        keyA = a[31] ? ~a : (a ^ 32'h80000000);
        keyB = b[31] ? ~b : (b ^ 32'h80000000);
        eq   = (a == b) || (modelIsZero(a) && modelIsZero(b));
        lt   = !eq && (keyA < keyB);
        return {lt, lt | eq, eq};
endfunction

function automatic logic [31:0] modelMinMax(input logic [31:0] a, input logic [31:0] b,
                                            input logic isMax);
        logic [31:0] keyA;
        logic [31:0] keyB;
        if (modelIsNan(a) && modelIsNan(b)) begin
                return 32'h7FC00000;
        end
        if (modelIsNan(a)) begin
                return b;
        end
        if (modelIsNan(b)) begin
                return a;
        end
        keyA = a[31] ? ~a : (a ^ 32'h80000000);
        keyB = b[31] ? ~b : (b ^ 32'h80000000);
        return ((keyA < keyB) ^ isMax) ? a : b;
endfunction

function automatic logic [31:0] modelCvt(input logic [31:0] x, input logic isUnsigned);
        logic        sign;
        logic [31:0] mag;
        logic [7:0]  rest;
        logic        roundUp;
        logic [24:0] rounded;
        int          shift;
        if (x == 32'b0) begin
                return 32'b0;
        end
        sign  = !isUnsigned && x[31];
        mag   = sign ? -x : x;
        shift = 0;
        while (!mag[31]) begin
                mag   = mag << 1;
                shift = shift + 1;
        end
        rest    = mag[7:0];
        // Past the halfway point, or on it with an odd kept lsb
        roundUp = (rest > 8'h80) || ((rest == 8'h80) && mag[8]);
        rounded = {1'b0, mag[31:8]} + 25'(roundUp);
        return {sign, 8'(158 - shift) + 8'(rounded[24]), rounded[22:0]};
endfunction

`endif

//--- testbench/fpuTb.sv
//**************************************************************************
// Self-checking testbench for the RV32F FPU, random operands from a fixed
// seed are checked against the reference model in fpuModel.svh
//**************************************************************************
`default_nettype none

module fpuTb;

import fpuOpsPkg::*;

`include "fpuModel.svh"

localparam int CASES       = 200;
localparam int CVT_TIMEOUT = 40;

typedef struct packed {
        logic [31:0] instr;
        logic [31:0] rs1;
        logic [31:0] rs2;
} stim_t;

logic        clk;
logic        reset;
logic        fpuEnable;
logic [31:0] instr;
logic [31:0] rs1;
logic [31:0] rs2;
logic        busy;
logic [31:0] fpuOut;

logic [31:0] rngState;
int          errors;
int          testErrors;
int          testsDone;
int          testsBad;

FPU u_dut (
        .clk_i(clk),
        .reset_i(reset),
        .fpuEnable_i(fpuEnable),
        .instr_i(instr),
        .rs1_i(rs1),
        .rs2_i(rs2),
        .busy_o(busy),
        .fpuOut_o(fpuOut)
);

always #5 clk = ~clk;

function automatic logic [31:0] nextRand();
        rngState = lcg(rngState);
        return rngState;
endfunction

// Zeros, infinities, qNaN, sNaN, a subnormal and 1.0
function automatic logic [31:0] specialValue(input logic [2:0] idx);
        case (idx)
                3'd0:    return 32'h00000000;
                3'd1:    return 32'h80000000;
                3'd2:    return 32'h7f800000;
                3'd3:    return 32'hff800000;
                3'd4:    return 32'h7fc00000;
                3'd5:    return 32'h7f800001;
                3'd6:    return 32'h00000123;
                default: return 32'h3f800000;
        endcase
endfunction

function automatic logic [31:0] randOperand();
        logic [31:0] r;
        r = nextRand();
        if (r[31:30] == 2'b00) begin
                return specialValue(r[18:16]);
        end
        return nextRand();
endfunction

// Short values give long normalization runs
function automatic logic [31:0] randInt();
        logic [31:0] r;
        logic [31:0] v;
        r = nextRand();
        v = nextRand();
        case (r[31:29])
                3'd0:    return 32'b0;
                3'd1:    return 32'h80000000;
                3'd2:    return v >> r[20:16];
                3'd3:    return -(v >> r[20:16]);
                default: return v;
        endcase
endfunction

task automatic checkValue(input string name, input logic [31:0] expected,
                          input logic [31:0] actual);
        assert (actual === expected)
        else begin
                $display("[ERROR] t=%0t %s expected %h actual %h", $time, name, expected,
                         actual);
                testErrors++;
        end
endtask

task automatic applyStim(input stim_t s);
        @(negedge clk);
        fpuEnable = 1'b1;
        instr     = s.instr;
        rs1       = s.rs1;
        rs2       = s.rs2;
endtask

task automatic finishTest(input string title);
        testsDone++;
        if (testErrors == 0) begin
                $display("[TEST] %s: ok", title);
        end else begin
                testsBad++;
                $display("[TEST] %s: %0d errors", title, testErrors);
        end
        errors     += testErrors;
        testErrors = 0;
endtask

task automatic testReset();
        @(negedge clk);
        checkValue("busy_o", 32'b0, {31'b0, busy});
        finishTest("reset");
endtask

task automatic testSgnjMoves();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] expected;
        logic [2:0]  sel;
        stim_t       s;
        for (int i = 0; i < CASES; i++) begin
                a   = randOperand();
                b   = randOperand();
                sel = 3'(nextRand() >> 16) % 3'd5;
                if (sel < 3'd3) begin
                        s.instr  = fpInstr(FUNCT5_SGNJ, 5'd3, sel);
                        expected = modelSgnj(a, b, sel[1:0]);
                end else if (sel == 3'd3) begin
                        s.instr  = fpInstr(FUNCT5_MVXW_CLASS, RS2_W, FUNCT3_MV);
                        expected = a;
                end else begin
                        s.instr  = fpInstr(FUNCT5_MVWX, RS2_W, FUNCT3_MV);
                        expected = a;
                end
                s.rs1 = a;
                s.rs2 = b;
                applyStim(s);
                @(posedge clk);
                checkValue("fpuOut_o", expected, fpuOut);
                checkValue("busy_o", 32'b0, {31'b0, busy});
        end
        finishTest("sign injection and moves");
endtask

task automatic testCompare();
        logic [31:0] a;
        logic [31:0] b;
        logic [2:0]  cmp;
        logic [1:0]  sel;
        logic        expected;
        stim_t       s;
        for (int i = 0; i < CASES; i++) begin
                a     = randOperand();
                b     = (nextRand() < 32'h40000000) ? a : randOperand();
                sel   = 2'(nextRand() >> 16) % 2'd3;
                cmp   = modelCmp(a, b);
                s.rs1 = a;
                s.rs2 = b;
                // funct3 0 is FLE, 1 is FLT, 2 is FEQ
                s.instr = fpInstr(FUNCT5_CMP, 5'd3, {1'b0, sel});
                case ({1'b0, sel})
                        FUNCT3_FLE: expected = cmp[1];
                        FUNCT3_FLT: expected = cmp[2];
                        default:    expected = cmp[0];
                endcase
                applyStim(s);
                @(posedge clk);
                checkValue("fpuOut_o", {31'b0, expected}, fpuOut);
        end
        finishTest("compares");
endtask

task automatic testMinMax();
        logic [31:0] a;
        logic [31:0] b;
        logic        isMax;
        stim_t       s;
        for (int i = 0; i < CASES; i++) begin
                a       = randOperand();
                b       = randOperand();
                isMax   = nextRand() >= 32'h80000000;
                s.rs1   = a;
                s.rs2   = b;
                s.instr = fpInstr(FUNCT5_MINMAX, 5'd3, isMax ? FUNCT3_MAX : FUNCT3_MIN);
                applyStim(s);
                @(posedge clk);
                checkValue("fpuOut_o", modelMinMax(a, b, isMax), fpuOut);
        end
        finishTest("min and max");
endtask

task automatic testClassify();
        logic [31:0] a;
        stim_t       s;
        for (int i = 0; i < CASES; i++) begin
                a       = randOperand();
                s.rs1   = a;
                s.rs2   = randOperand();
                s.instr = fpInstr(FUNCT5_MVXW_CLASS, RS2_W, FUNCT3_CLASS);
                applyStim(s);
                @(posedge clk);
                assert ($onehot(fpuOut))
                else begin
                        $display("FCLASS of %h at t=%0t gave %h, not exactly one bit set",
                                 a, $time, fpuOut);
                        testErrors++;
                end
                checkValue("fpuOut_o", {22'b0, modelClass(a)}, fpuOut);
        end
        finishTest("classify");
endtask

task automatic testConvert();
        logic [31:0] x;
        logic        isUnsigned;
        int          cycles;
        stim_t       s;
        for (int i = 0; i < CASES; i++) begin
                x          = randInt();
                isUnsigned = nextRand() >= 32'h80000000;
                s.rs1      = x;
                s.rs2      = randOperand();
                s.instr    = fpInstr(FUNCT5_CVTSW, isUnsigned ? RS2_WU : RS2_W, 3'b000);
                applyStim(s);
                cycles = 0;
                @(negedge clk);
                while (busy && (cycles < CVT_TIMEOUT)) begin
                        @(negedge clk);
                        cycles++;
                end
                if (busy) begin
                        $display("Conversion of %h did not finish within %0d cycles",
                                 x, CVT_TIMEOUT);
                        testErrors++;
                        break;
                end
                checkValue("fpuOut_o", modelCvt(x, isUnsigned), fpuOut);
                // Drop enable so the converter returns to idle
                fpuEnable = 1'b0;
        end
        fpuEnable = 1'b0;
        finishTest("integer to float conversion");
endtask

initial begin
        clk        = 1'b0;
        reset      = 1'b1;
        fpuEnable  = 1'b0;
        instr      = 32'b0;
        rs1        = 32'b0;
        rs2        = 32'b0;
        rngState   = LCG_SEED;
        errors     = 0;
        testErrors = 0;
        testsDone  = 0;
        testsBad   = 0;
        repeat (8) @(negedge clk);
        reset = 1'b0;

        testReset();
        testSgnjMoves();
        testCompare();
        testMinMax();
        testClassify();
        testConvert();

        $display("[SUMMARY] %0d tests, %0d ok, %0d with errors, %0d errors in total",
                 testsDone, testsDone - testsBad, testsBad, errors);
        if (errors == 0) begin
                $display("test passed");
        end else begin
                $display("test failed");
        end
        $finish;
end

endmodule

`default_nettype wire

//--- src.f
+incdir+include
design/fpuOpsPkg.sv
design/fpuDataPkg.sv
design/FDecode.sv
design/FClass.sv
design/FCMP.sv
design/FCVT.sv
design/FResult.sv
design/FPU.sv
testbench/fpuTb.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -Wno-fatal
TOP       ?= fpuTb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "test failed" $(LOG); then \
		echo "Simulation reported failure"; exit 1; \
	fi
	@if ! grep -q "test passed" $(LOG); then \
		echo "Simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
